// File: hdl/arm_isa_pkg.sv
// ARM-side field types and encodings; expanders pull these by scoped name to build 32-bit words
package arm_isa_pkg;

        ////////////////////
        // Field types
        ////////////////////

        typedef logic [31:0] arm_instr_t;       // Full ARM instruction word
        typedef logic [3:0]  arm_reg_t;         // Register number r0..r15
        typedef logic [3:0]  arm_cond_t;        // Condition, bits 31:28
        typedef logic [3:0]  arm_alu_op_t;      // DP opcode, bits 24:21

        localparam arm_cond_t COND_AL = 4'b1110; // Always execute

        ////////////////////
        // DP opcodes
        ////////////////////

        localparam arm_alu_op_t OP_AND = 4'd0;
        localparam arm_alu_op_t OP_EOR = 4'd1;
        localparam arm_alu_op_t OP_SUB = 4'd2;
        localparam arm_alu_op_t OP_RSB = 4'd3;  // Reverse subtract, used for NEG
        localparam arm_alu_op_t OP_ADD = 4'd4;
        localparam arm_alu_op_t OP_ADC = 4'd5;
        localparam arm_alu_op_t OP_SBC = 4'd6;
        localparam arm_alu_op_t OP_TST = 4'd8;
        localparam arm_alu_op_t OP_CMP = 4'd10;
        localparam arm_alu_op_t OP_CMN = 4'd11;
        localparam arm_alu_op_t OP_ORR = 4'd12;
        localparam arm_alu_op_t OP_MOV = 4'd13; // Also carries all shifts
        localparam arm_alu_op_t OP_BIC = 4'd14;
        localparam arm_alu_op_t OP_MVN = 4'd15;

        // Shifter type, bits 6:5
        localparam logic [1:0] SH_LSL = 2'b00;
        localparam logic [1:0] SH_LSR = 2'b01;
        localparam logic [1:0] SH_ASR = 2'b10;
        localparam logic [1:0] SH_ROR = 2'b11;

        localparam arm_reg_t REG_SP = 4'd13;    // Stack pointer

        ////////////////////
        // Class fields
        ////////////////////

        localparam logic [1:0] CLASS_DP          = 2'b00;  // Bits 27:26
        localparam logic [2:0] CLASS_LDST        = 3'b010; // Bits 27:25, immediate offset
        localparam logic [2:0] CLASS_LDST_REGFMT = 3'b011; // Register offset word/byte
        localparam logic [2:0] CLASS_HALF        = 3'b000; // Halfword and signed transfers

        // Rotate field giving imm << 2 (ror by 30)
        localparam logic [3:0] ROT_SHL2 = 4'd15;

endpackage

// File: hdl/thumb_pkg.sv
// Compressed-side patterns, group codes and queue/credit sizing shared by the decode RTL
package thumb_pkg;

        typedef logic [15:0] thumb_half_t;      // One compressed halfword
        typedef logic [3:0]  thumb_group_t;     // Decoded group code
        typedef logic [2:0]  credit_cnt_t;      // Occupancy and credit counters

        ////////////////////
        // Group codes
        ////////////////////

        localparam thumb_group_t GRP_NONE           = 4'd0; // Dropped or unknown
        localparam thumb_group_t GRP_SHIFT          = 4'd1;
        localparam thumb_group_t GRP_ADD_SUB_LO     = 4'd2;
        localparam thumb_group_t GRP_MCAS_IMM       = 4'd3;
        localparam thumb_group_t GRP_ALU_LO         = 4'd4;
        localparam thumb_group_t GRP_ALU_HI         = 4'd5;
        localparam thumb_group_t GRP_LDR_STR_OFF5   = 4'd6;
        localparam thumb_group_t GRP_LDRH_STRH_OFF5 = 4'd7;
        localparam thumb_group_t GRP_LDRH_STRH_REG  = 4'd8;
        localparam thumb_group_t GRP_SP_REL         = 4'd9;

        ////////////////////
        // Match patterns
        ////////////////////

        // ? bits are wildcards in casez and ==?
        localparam thumb_half_t PAT_ADD_SUB_LO     = 16'b0001_1???_????_????;
        localparam thumb_half_t PAT_SHIFT          = 16'b000?_????_????_????; // After ADD/SUB
        localparam thumb_half_t PAT_MCAS_IMM       = 16'b001?_????_????_????;
        localparam thumb_half_t PAT_ALU_LO         = 16'b0100_00??_????_????;
        localparam thumb_half_t PAT_ALU_HI         = 16'b0100_01??_????_????; // BX lands in op 3
        localparam thumb_half_t PAT_LDRH_STRH_REG  = 16'b0101_????_????_????;
        localparam thumb_half_t PAT_LDR_STR_OFF5   = 16'b011?_????_????_????;
        localparam thumb_half_t PAT_LDRH_STRH_OFF5 = 16'b1000_????_????_????;
        localparam thumb_half_t PAT_SP_REL         = 16'b1001_????_????_????;

        ////////////////////
        // Flow control
        ////////////////////

        localparam credit_cnt_t QUEUE_DEPTH  = 3'd4; // Entries, also initial upstream credits
        localparam credit_cnt_t DOWN_CREDITS = 3'd4; // Sink slots assumed after reset

endpackage

// File: hdl/thumb_classify.sv
// Matches a compressed halfword against the kept patterns and reports its group code
module thumb_classify (
        input  thumb_pkg::thumb_half_t  i_half,
        output thumb_pkg::thumb_group_t o_group
);

// ADD/SUB low overlaps the shift pattern so it wins first
always_comb
begin
        o_group = thumb_pkg::GRP_NONE;

        if (i_half ==? thumb_pkg::PAT_ADD_SUB_LO)
        begin
                o_group = thumb_pkg::GRP_ADD_SUB_LO;
        end
        else
        begin
                casez (i_half)
                thumb_pkg::PAT_SHIFT:
                        o_group = thumb_pkg::GRP_SHIFT;         // LSL/LSR/ASR imm
                thumb_pkg::PAT_MCAS_IMM:
                        o_group = thumb_pkg::GRP_MCAS_IMM;      // MOV/CMP/ADD/SUB #imm8
                thumb_pkg::PAT_ALU_LO:
                        o_group = thumb_pkg::GRP_ALU_LO;
                thumb_pkg::PAT_ALU_HI:
                        o_group = thumb_pkg::GRP_ALU_HI;
                thumb_pkg::PAT_LDRH_STRH_REG:
                        o_group = thumb_pkg::GRP_LDRH_STRH_REG; // All reg-offset forms
                thumb_pkg::PAT_LDR_STR_OFF5:
                        o_group = thumb_pkg::GRP_LDR_STR_OFF5;
                thumb_pkg::PAT_LDRH_STRH_OFF5:
                        o_group = thumb_pkg::GRP_LDRH_STRH_OFF5;
                thumb_pkg::PAT_SP_REL:
                        o_group = thumb_pkg::GRP_SP_REL;
                default:
                        o_group = thumb_pkg::GRP_NONE;          // Branch, SWI, PUSH etc.
                endcase
        end
end

endmodule

// File: hdl/thumb_alu_expand.sv
// Expands the five compressed data-processing groups into always-condition ARM DP words
module thumb_alu_expand (
        input  thumb_pkg::thumb_half_t   i_half,
        input  thumb_pkg::thumb_group_t  i_group,
        output arm_isa_pkg::arm_instr_t  o_instruction,
        output logic                     o_und
);

// Packs cond, class, I, opcode, S, Rn, Rd and operand 2
function automatic arm_isa_pkg::arm_instr_t dp_word (
        input logic                      imm,
        input arm_isa_pkg::arm_alu_op_t  op,
        input logic                      set_flags,
        input arm_isa_pkg::arm_reg_t     rn,
        input arm_isa_pkg::arm_reg_t     rd,
        input logic [11:0]               op2
);
        return {arm_isa_pkg::COND_AL, arm_isa_pkg::CLASS_DP, imm, op, set_flags, rn, rd, op2};
endfunction

arm_isa_pkg::arm_reg_t rd, rs, rn, ri, hi_rd, hi_rs;

assign rd    = {1'b0, i_half[2:0]};
assign rs    = {1'b0, i_half[5:3]};
assign rn    = {1'b0, i_half[8:6]};        // Also the 3-bit immediate
assign ri    = {1'b0, i_half[10:8]};       // Rd of the imm8 forms
assign hi_rd = {i_half[7], i_half[2:0]};   // H1 extends Rd
assign hi_rs = {i_half[6], i_half[5:3]};   // H2 extends Rs

always_comb
begin
        o_instruction = '0;
        o_und         = 1'b0;

        case (i_group)
        thumb_pkg::GRP_SHIFT: // MOVS Rd, Rs, <sh> #amt
                o_instruction = dp_word(1'b0, arm_isa_pkg::OP_MOV, 1'b1, 4'd0, rd,
                                        {i_half[10:6], i_half[12:11], 1'b0, rs});
        thumb_pkg::GRP_ADD_SUB_LO: // Bit 10 picks imm3, bit 9 picks SUB
                o_instruction = dp_word(i_half[10],
                                        i_half[9] ? arm_isa_pkg::OP_SUB : arm_isa_pkg::OP_ADD,
                                        1'b1, rs, rd, {8'd0, rn});
        thumb_pkg::GRP_MCAS_IMM:
        begin
                case (i_half[12:11])
                2'd0: o_instruction = dp_word(1'b1, arm_isa_pkg::OP_MOV, 1'b1, ri, ri,
                                             {4'd0, i_half[7:0]});
                2'd1: o_instruction = dp_word(1'b1, arm_isa_pkg::OP_CMP, 1'b1, ri, ri,
                                             {4'd0, i_half[7:0]});
                2'd2: o_instruction = dp_word(1'b1, arm_isa_pkg::OP_ADD, 1'b1, ri, ri,
                                             {4'd0, i_half[7:0]});
                default: o_instruction = dp_word(1'b1, arm_isa_pkg::OP_SUB, 1'b1, ri, ri,
                                                {4'd0, i_half[7:0]});
                endcase
        end
        thumb_pkg::GRP_ALU_LO:
        begin
                case (i_half[9:6])
                4'd0:  o_instruction = dp_word(1'b0, arm_isa_pkg::OP_AND, 1'b1, rd, rd, {8'd0, rs});
                4'd1:  o_instruction = dp_word(1'b0, arm_isa_pkg::OP_EOR, 1'b1, rd, rd, {8'd0, rs});
                4'd2:  o_instruction = dp_word(1'b0, arm_isa_pkg::OP_MOV, 1'b1, rd, rd,
                                               {rs, 1'b0, arm_isa_pkg::SH_LSL, 1'b1, rd});
                4'd3:  o_instruction = dp_word(1'b0, arm_isa_pkg::OP_MOV, 1'b1, rd, rd,
                                               {rs, 1'b0, arm_isa_pkg::SH_LSR, 1'b1, rd});
                4'd4:  o_instruction = dp_word(1'b0, arm_isa_pkg::OP_MOV, 1'b1, rd, rd,
                                               {rs, 1'b0, arm_isa_pkg::SH_ASR, 1'b1, rd});
                4'd5:  o_instruction = dp_word(1'b0, arm_isa_pkg::OP_ADC, 1'b1, rd, rd, {8'd0, rs});
                4'd6:  o_instruction = dp_word(1'b0, arm_isa_pkg::OP_SBC, 1'b1, rd, rd, {8'd0, rs});
                4'd7:  o_instruction = dp_word(1'b0, arm_isa_pkg::OP_MOV, 1'b1, rd, rd,
                                               {rs, 1'b0, arm_isa_pkg::SH_ROR, 1'b1, rd});
                4'd8:  o_instruction = dp_word(1'b0, arm_isa_pkg::OP_TST, 1'b1, rd, rd, {8'd0, rs});
                4'd9:  o_instruction = dp_word(1'b1, arm_isa_pkg::OP_RSB, 1'b1, rs, rd, 12'd0);
                4'd10: o_instruction = dp_word(1'b0, arm_isa_pkg::OP_CMP, 1'b1, rd, rd, {8'd0, rs});
                4'd11: o_instruction = dp_word(1'b0, arm_isa_pkg::OP_CMN, 1'b1, rd, rd, {8'd0, rs});
                4'd12: o_instruction = dp_word(1'b0, arm_isa_pkg::OP_ORR, 1'b1, rd, rd, {8'd0, rs});
                4'd13: // MULS Rd, Rs, Rd in the multiply encoding
                       o_instruction = {arm_isa_pkg::COND_AL, 7'b0000_000, 1'b1,
                                        rd, 4'd0, rd, 4'b1001, rs};
                4'd14: o_instruction = dp_word(1'b0, arm_isa_pkg::OP_BIC, 1'b1, rd, rd, {8'd0, rs});
                default: o_instruction = dp_word(1'b0, arm_isa_pkg::OP_MVN, 1'b1, rd, rd,
                                                 {8'd0, rs});
                endcase
        end
        thumb_pkg::GRP_ALU_HI:
        begin
                case (i_half[9:8])
                2'd0: o_instruction = dp_word(1'b0, arm_isa_pkg::OP_ADD, 1'b0, hi_rd, hi_rd,
                                              {8'd0, hi_rs});
                2'd1: o_instruction = dp_word(1'b0, arm_isa_pkg::OP_CMP, 1'b1, hi_rd, hi_rd,
                                              {8'd0, hi_rs});
                2'd2: o_instruction = dp_word(1'b0, arm_isa_pkg::OP_MOV, 1'b0, hi_rd, hi_rd,
                                              {8'd0, hi_rs});
                default: o_und = 1'b1; // Op 3 has no expansion here
                endcase
        end
        default: ; // Not a DP group
        endcase
end

endmodule

// File: hdl/thumb_ldst_expand.sv
// Expands the four compressed load/store groups into pre-indexed ARM transfers
module thumb_ldst_expand (
        input  thumb_pkg::thumb_half_t   i_half,
        input  thumb_pkg::thumb_group_t  i_group,
        output arm_isa_pkg::arm_instr_t  o_instruction
);

arm_isa_pkg::arm_reg_t rd, rb, ro, ri;
logic [7:0]  half_off;   // imm5 * 2, split into nibbles
logic [11:0] wb_off;     // Word or byte offset
logic [11:0] sp_off;     // imm8 * 4
logic        hs_sign, hs_high;

assign rd      = {1'b0, i_half[2:0]};
assign rb      = {1'b0, i_half[5:3]};    // Base
assign ro      = {1'b0, i_half[8:6]};    // Offset register
assign ri      = {1'b0, i_half[10:8]};   // SP-relative Rd
assign hs_sign = i_half[10];
assign hs_high = i_half[11];

assign half_off = {2'b00, i_half[10:6], 1'b0};
assign wb_off   = i_half[12] ? {7'd0, i_half[10:6]} : {5'd0, i_half[10:6], 2'b00};

// Ror by 2*ROT equals shl by 32 - 2*ROT
assign sp_off = 12'(i_half[7:0]) << (32 - 2 * arm_isa_pkg::ROT_SHL2);

always_comb
begin
        o_instruction = '0;

        case (i_group)
        thumb_pkg::GRP_LDR_STR_OFF5: // P U B W L
                o_instruction = {arm_isa_pkg::COND_AL, arm_isa_pkg::CLASS_LDST,
                                 1'b1, 1'b1, i_half[12], 1'b0, i_half[11], rb, rd, wb_off};
        thumb_pkg::GRP_LDRH_STRH_OFF5: // P U I W = 1110
                o_instruction = {arm_isa_pkg::COND_AL, arm_isa_pkg::CLASS_HALF, 4'b1110,
                                 i_half[11], rb, rd, half_off[7:4],
                                 1'b1, 2'b01, 1'b1, half_off[3:0]};
        thumb_pkg::GRP_LDRH_STRH_REG:
        begin
                if (!i_half[9]) // STR, STRB, LDR, LDRB
                        o_instruction = {arm_isa_pkg::COND_AL, arm_isa_pkg::CLASS_LDST_REGFMT,
                                         1'b1, 1'b1, hs_sign, 1'b0, hs_high,
                                         rb, rd, 8'd0, ro};
                else // STRH, LDRH, LDSB, LDSH
                        o_instruction = {arm_isa_pkg::COND_AL, arm_isa_pkg::CLASS_HALF,
                                         1'b1, 1'b1, 1'b0, 1'b0, hs_sign | hs_high,
                                         rb, rd, 4'd0, 1'b1,
                                         {hs_sign, hs_high | ~hs_sign}, // SH field
                                         1'b1, ro};
        end
        thumb_pkg::GRP_SP_REL: // Word only, base SP
                o_instruction = {arm_isa_pkg::COND_AL, arm_isa_pkg::CLASS_LDST,
                                 1'b1, 1'b1, 1'b0, 1'b0, i_half[11],
                                 arm_isa_pkg::REG_SP, ri, sp_off};
        default: ; // Not a load/store group
        endcase
end

endmodule

// File: hdl/decode_stage.sv
// Registered decode stage; expands compressed halfwords or passes ARM words, one cycle latency
module decode_stage (
        input  logic                     i_clk,
        input  logic                     i_reset,
        input  logic                     i_valid,
        input  logic                     i_thumb,
        input  arm_isa_pkg::arm_instr_t  i_instruction,
        output logic                     o_valid,
        output arm_isa_pkg::arm_instr_t  o_instruction,
        output logic                     o_und
);

thumb_pkg::thumb_group_t  group;
arm_isa_pkg::arm_instr_t  alu_word, ldst_word, next_word;
logic                     alu_und, next_und;

thumb_classify u_classify (
        .i_half  (i_instruction[15:0]),
        .o_group (group)
);

thumb_alu_expand u_alu (
        .i_half        (i_instruction[15:0]),
        .i_group       (group),
        .o_instruction (alu_word),
        .o_und         (alu_und)
);

thumb_ldst_expand u_ldst (
        .i_half        (i_instruction[15:0]),
        .i_group       (group),
        .o_instruction (ldst_word)
);

// Unowned groups give zero so OR merges
always_comb
begin
        next_word = i_instruction;      // ARM state
        next_und  = 1'b0;
        if (i_thumb)
        begin
                next_word = alu_word | ldst_word;
                next_und  = (group == thumb_pkg::GRP_NONE) || alu_und;
        end
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
                o_valid <= 1'b0;
        else
                o_valid <= i_valid;
        o_instruction <= next_word;
        o_und         <= next_und;
end

// One expander owns each group
a_one_expander: assert property (@(posedge i_clk) disable iff (i_reset)
        !((|alu_word) && (|ldst_word)));

endmodule

// File: hdl/issue_queue.sv
// Credit-controlled issue queue; returns upstream credits on issue and spends downstream ones
module issue_queue (
        input  logic                     i_clk,
        input  logic                     i_reset,
        input  logic                     i_valid,
        input  arm_isa_pkg::arm_instr_t  i_instruction,
        input  logic                     i_und,
        input  logic                     i_credit,
        output logic                     o_valid,
        output arm_isa_pkg::arm_instr_t  o_instruction,
        output logic                     o_und,
        output logic                     o_credit
);

////////////////////
// Storage
////////////////////

arm_isa_pkg::arm_instr_t  mem_instr [thumb_pkg::QUEUE_DEPTH];
logic                     mem_und   [thumb_pkg::QUEUE_DEPTH];

logic [$clog2(thumb_pkg::QUEUE_DEPTH)-1:0] wr_ptr, rd_ptr;
thumb_pkg::credit_cnt_t   count;        // Stored entries
thumb_pkg::credit_cnt_t   credits;      // Free sink slots
logic                     issue;

// Head goes out once there is an entry and a sink slot
assign issue         = (count != '0) && (credits != '0);
assign o_valid       = issue;
assign o_credit      = issue;           // Freed entry returns upstream
assign o_instruction = mem_instr[rd_ptr];
assign o_und         = mem_und[rd_ptr];

always_ff @(posedge i_clk)
begin
        if (i_valid)
        begin
                mem_instr[wr_ptr] <= i_instruction;
                mem_und[wr_ptr]   <= i_und;
        end
end

////////////////////
// Pointers, counts
////////////////////

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                wr_ptr  <= '0;
                rd_ptr  <= '0;
                count   <= '0;
                credits <= thumb_pkg::DOWN_CREDITS;
        end
        else
        begin
                if (i_valid)
                        wr_ptr <= (wr_ptr == $bits(wr_ptr)'(thumb_pkg::QUEUE_DEPTH - 1)) ?
                                  '0 : wr_ptr + 1'b1;
                if (issue)
                        rd_ptr <= (rd_ptr == $bits(rd_ptr)'(thumb_pkg::QUEUE_DEPTH - 1)) ?
                                  '0 : rd_ptr + 1'b1;

                case ({i_valid, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;      // Idle or push with pop
                endcase

                case ({issue, i_credit})
                2'b10:   credits <= credits - 1'b1;  // Transfer spends a slot
                2'b01:   credits <= credits + 1'b1;  // Sink freed one
                default: ;
                endcase
        end
end

// Upstream credits keep the queue from overflowing
a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset)
        i_valid |-> (count != thumb_pkg::QUEUE_DEPTH));

// Sink never returns more than it was given
a_credit_max: assert property (@(posedge i_clk) disable iff (i_reset)
        credits <= thumb_pkg::DOWN_CREDITS);

endmodule

// File: hdl/thumb_expand_top.sv
// Top level of the queued compressed-instruction expander; decode stage feeding the issue queue
module thumb_expand_top (
        input  logic                     i_clk,
        input  logic                     i_reset,
        input  logic                     i_valid,
        input  logic                     i_thumb,
        input  arm_isa_pkg::arm_instr_t  i_instruction,
        input  logic                     i_credit,
        output logic                     o_valid,
        output arm_isa_pkg::arm_instr_t  o_instruction,
        output logic                     o_und,
        output logic                     o_credit
);

logic                     s_valid;      // Decode register to queue
arm_isa_pkg::arm_instr_t  s_instruction;
logic                     s_und;

decode_stage u_decode (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_thumb       (i_thumb),
        .i_instruction (i_instruction),
        .o_valid       (s_valid),
        .o_instruction (s_instruction),
        .o_und         (s_und)
);

issue_queue u_queue (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_valid       (s_valid),
        .i_instruction (s_instruction),
        .i_und         (s_und),
        .i_credit      (i_credit),
        .o_valid       (o_valid),
        .o_instruction (o_instruction),
        .o_und         (o_und),
        .o_credit      (o_credit)
);

endmodule

// File: test/tb_vectors.svh
// Table of stimulus rows and expected expansions, included by the expander testbench
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Row layout {thumb, input word, expected instruction, expected und}
localparam int NUM_VECTORS = 48;

function automatic logic [65:0] get_vector(input int idx);
        logic [65:0] row;
        row = '0;
        case (idx)
        0:  row = {1'b0, 32'hE081_2003, 32'hE081_2003, 1'b0}; // ARM words pass through
        1:  row = {1'b0, 32'h1234_ABCD, 32'h1234_ABCD, 1'b0};
        2:  row = {1'b0, 32'hDEAD_E005, 32'hDEAD_E005, 1'b0}; // Branch-like low half ignored
        3:  row = {1'b1, 32'h0000_00D1, 32'hE1B0_1182, 1'b0}; // LSL r1, r2, #3
        4:  row = {1'b1, 32'hFFFF_0FE3, 32'hE1B0_3FA4, 1'b0}; // LSR #31, upper half junk
        5:  row = {1'b1, 32'h0000_1078, 32'hE1B0_00C7, 1'b0}; // ASR r0, r7, #1
        6:  row = {1'b1, 32'h0000_18D1, 32'hE092_1003, 1'b0}; // ADD r1, r2, r3
        7:  row = {1'b1, 32'h0000_1FEC, 32'hE255_4007, 1'b0}; // SUB r4, r5, #7
        8:  row = {1'b1, 32'h0000_2255, 32'hE3B2_2055, 1'b0}; // MOV r2, #0x55
        9:  row = {1'b1, 32'h0000_2FFF, 32'hE357_70FF, 1'b0}; // CMP r7, #0xFF
        10: row = {1'b1, 32'h0000_3001, 32'hE290_0001, 1'b0}; // ADD r0, #1
        11: row = {1'b1, 32'h0000_3D80, 32'hE255_5080, 1'b0}; // SUB r5, #0x80
        // Low-register ALU ops 0..15, Rd r1, Rs r2
        12: row = {1'b1, 32'h0000_4011, 32'hE011_1002, 1'b0}; // AND
        13: row = {1'b1, 32'h0000_4051, 32'hE031_1002, 1'b0}; // EOR
        14: row = {1'b1, 32'h0000_4091, 32'hE1B1_1211, 1'b0}; // LSL by reg
        15: row = {1'b1, 32'h0000_40D1, 32'hE1B1_1231, 1'b0}; // LSR by reg
        16: row = {1'b1, 32'h0000_4111, 32'hE1B1_1251, 1'b0}; // ASR by reg
        17: row = {1'b1, 32'h0000_4151, 32'hE0B1_1002, 1'b0}; // ADC
        18: row = {1'b1, 32'h0000_4191, 32'hE0D1_1002, 1'b0}; // SBC
        19: row = {1'b1, 32'h0000_41D1, 32'hE1B1_1271, 1'b0}; // ROR by reg
        20: row = {1'b1, 32'h0000_4211, 32'hE111_1002, 1'b0}; // TST
        21: row = {1'b1, 32'h0000_4251, 32'hE272_1000, 1'b0}; // NEG as RSB #0
        22: row = {1'b1, 32'h0000_4291, 32'hE151_1002, 1'b0}; // CMP
        23: row = {1'b1, 32'h0000_42D1, 32'hE171_1002, 1'b0}; // CMN
        24: row = {1'b1, 32'h0000_4311, 32'hE191_1002, 1'b0}; // ORR
        25: row = {1'b1, 32'h0000_4351, 32'hE011_0192, 1'b0}; // MUL
        26: row = {1'b1, 32'h0000_4391, 32'hE1D1_1002, 1'b0}; // BIC
        27: row = {1'b1, 32'h0000_43D1, 32'hE1F1_1002, 1'b0}; // MVN
        28: row = {1'b1, 32'h0000_4491, 32'hE089_9002, 1'b0}; // ADD r9, r2
        29: row = {1'b1, 32'h0000_4561, 32'hE151_100C, 1'b0}; // CMP r1, r12
        30: row = {1'b1, 32'h0000_46EE, 32'hE1AE_E00D, 1'b0}; // MOV r14, r13
        31: row = {1'b1, 32'h0000_4708, 32'h0000_0000, 1'b1}; // Hi op 3 undefined
        32: row = {1'b1, 32'h0000_6091, 32'hE582_1008, 1'b0}; // STR r1, [r2, #8]
        33: row = {1'b1, 32'h0000_7FE3, 32'hE5D4_301F, 1'b0}; // LDRB r3, [r4, #31]
        34: row = {1'b1, 32'h0000_6FF8, 32'hE597_007C, 1'b0}; // LDR r0, [r7, #124]
        35: row = {1'b1, 32'h0000_80D1, 32'hE1C2_10B6, 1'b0}; // STRH r1, [r2, #6]
        36: row = {1'b1, 32'h0000_8FF5, 32'hE1D6_53BE, 1'b0}; // LDRH r5, [r6, #62]
        37: row = {1'b1, 32'h0000_50D1, 32'hE782_1003, 1'b0}; // STR r1, [r2, r3]
        38: row = {1'b1, 32'h0000_5DAC, 32'hE7D5_4006, 1'b0}; // LDRB r4, [r5, r6]
        39: row = {1'b1, 32'h0000_52D1, 32'hE182_10B3, 1'b0}; // STRH reg offset
        40: row = {1'b1, 32'h0000_5AD1, 32'hE192_10B3, 1'b0}; // LDRH reg offset
        41: row = {1'b1, 32'h0000_56D1, 32'hE192_10D3, 1'b0}; // LDSB
        42: row = {1'b1, 32'h0000_5ED1, 32'hE192_10F3, 1'b0}; // LDSH
        43: row = {1'b1, 32'h0000_9204, 32'hE58D_2010, 1'b0}; // STR r2, [sp, #16]
        44: row = {1'b1, 32'h0000_9FFF, 32'hE59D_73FC, 1'b0}; // LDR r7, [sp, #1020]
        45: row = {1'b1, 32'h0000_E005, 32'h0000_0000, 1'b1}; // Branch dropped
        46: row = {1'b1, 32'h0000_DF12, 32'h0000_0000, 1'b1}; // SWI dropped
        47: row = {1'b1, 32'h0000_B510, 32'h0000_0000, 1'b1}; // PUSH dropped
        default: row = '0;
        endcase
        return row;
endfunction

`endif

// File: test/tb_thumb_expand.sv
// Testbench for the queued expander; sends the vector table under credits and scores the outputs
module tb_thumb_expand;

logic                    clk, reset, valid, thumb, credit;
arm_isa_pkg::arm_instr_t instruction;
logic                    o_valid, o_und, o_credit;
arm_isa_pkg::arm_instr_t o_instruction;

int   up_credits, outstanding, credit_pulses, received, cycle;
int   tests_passed, tests_failed, next_row;
int   sent_q[$];                        // Row indices in send order
int   due_q[$];                         // Cycles at which sink credits go back
logic [31:0] lfsr;
logic        idle_ok, end_ok;

`include "tb_vectors.svh"

thumb_expand_top UUT (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_valid       (valid),
        .i_thumb       (thumb),
        .i_instruction (instruction),
        .i_credit      (credit),
        .o_valid       (o_valid),
        .o_instruction (o_instruction),
        .o_und         (o_und),
        .o_credit      (o_credit)
);

always #5 clk = ~clk;

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

////////////////////
// Sink side
////////////////////

task automatic score_output();
        logic [65:0] row;
        logic        ok;
        logic [1:0]  delay;
        int          idx, due;
        ok          = 1'b1;
        received    = received + 1;
        outstanding = outstanding + 1;
        assert (outstanding <= thumb_pkg::DOWN_CREDITS)
        else
        begin
                $display("more outputs outstanding than sink credits at %0t", $time);
                ok = 1'b0;
        end
        assert (sent_q.size() != 0)
        else
        begin
                $display("output arrived with nothing sent at %0t", $time);
                ok = 1'b0;
        end
        if (sent_q.size() != 0)
        begin
                idx = sent_q.pop_front();       // Oldest first keeps order
                row = get_vector(idx);
                assert (o_instruction === row[32:1])
                else
                begin
                        $display("FAIL %0t o_instruction expected %h got %h",
                                 $time, row[32:1], o_instruction);
                        ok = 1'b0;
                end
                assert (o_und === row[0])
                else
                begin
                        $display("FAIL %0t o_und expected %b got %b", $time, row[0], o_und);
                        ok = 1'b0;
                end
                $display("row %0d %s", idx, ok ? "ok" : "mismatch");
        end
        if (ok) tests_passed = tests_passed + 1;
        else tests_failed = tests_failed + 1;
        lfsr     = lfsr_next(lfsr);             // One step per delay bit
        delay[1] = lfsr[0];
        lfsr     = lfsr_next(lfsr);
        delay[0] = lfsr[0];
        due = cycle + delay;
        if (due_q.size() != 0 && due <= due_q[$])
                due = due_q[$] + 1;             // One pulse per cycle
        due_q.push_back(due);
endtask

always @(posedge clk)
begin
        if (!reset)
        begin
                cycle = cycle + 1;
                if (credit) outstanding = outstanding - 1;
                if (o_credit)
                begin
                        up_credits    = up_credits + 1;
                        credit_pulses = credit_pulses + 1;
                end
                if (o_valid) score_output();
        end
end

always @(posedge clk)
begin
        #1;
        credit = 1'b0;
        if (due_q.size() != 0 && due_q[0] <= cycle)
        begin
                credit = 1'b1;
                due_q.delete(0);
        end
end

////////////////////
// Source and checks
////////////////////

task automatic check_idle();
        assert (o_valid === 1'b0)
        else
        begin
                $display("FAIL %0t o_valid expected 0 got %b", $time, o_valid);
                idle_ok = 1'b0;
        end
        assert (o_credit === 1'b0)
        else
        begin
                $display("FAIL %0t o_credit expected 0 got %b", $time, o_credit);
                idle_ok = 1'b0;
        end
endtask

initial
begin
        clk           = 1'b0;
        reset         = 1'b1;
        valid         = 1'b0;
        thumb         = 1'b0;
        credit        = 1'b0;
        instruction   = '0;
        lfsr          = 32'h4996_5262;
        up_credits    = thumb_pkg::QUEUE_DEPTH;
        outstanding   = 0;
        credit_pulses = 0;
        received      = 0;
        cycle         = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        idle_ok       = 1'b1;
        end_ok        = 1'b1;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        check_idle();
        repeat (3)
        begin
                @(posedge clk);
                #1 check_idle();        // Nothing sent yet
        end
        if (idle_ok) tests_passed = tests_passed + 1;
        else tests_failed = tests_failed + 1;
        $display("reset idle %s", idle_ok ? "ok" : "mismatch");
        next_row = 0;
        while (next_row < NUM_VECTORS)
        begin
                @(posedge clk);
                #1 valid = 1'b0;
                if (up_credits > 0)     // Send only with a credit held
                begin
                        {thumb, instruction} = get_vector(next_row) >> 33;
                        valid      = 1'b1;
                        up_credits = up_credits - 1;
                        sent_q.push_back(next_row);
                        next_row   = next_row + 1;
                end
        end
        @(posedge clk);
        #1 valid = 1'b0;
        while (sent_q.size() != 0) @(posedge clk);
        repeat (8) @(posedge clk);      // Let sink credits drain
        assert (credit_pulses == NUM_VECTORS && received == NUM_VECTORS)
        else
        begin
                $display("got %0d credit pulses and %0d outputs for %0d rows sent",
                         credit_pulses, received, NUM_VECTORS);
                end_ok = 1'b0;
        end
        if (end_ok) tests_passed = tests_passed + 1;
        else tests_failed = tests_failed + 1;
        $display("credit totals %s", end_ok ? "ok" : "mismatch");
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
                $display("STATUS: PASS");
        else
                $display("STATUS: FAIL");
        $finish;
end

// Twenty cycles per row plus the reset
initial
begin
        #((NUM_VECTORS * 20 + 8) * 10);
        $display("watchdog expired with %0d outputs still missing", sent_q.size());
        $display("STATUS: FAIL");
        $finish;
end

endmodule

// File: filelist.f
+incdir+test
hdl/arm_isa_pkg.sv
hdl/thumb_pkg.sv
hdl/thumb_classify.sv
hdl/thumb_alu_expand.sv
hdl/thumb_ldst_expand.sv
hdl/decode_stage.sv
hdl/issue_queue.sv
hdl/thumb_expand_top.sv
test/tb_thumb_expand.sv

// File: Bender.yml
package:
  name: thumb_expand

sources:
  - files:
      - hdl/arm_isa_pkg.sv
      - hdl/thumb_pkg.sv
      - hdl/thumb_classify.sv
      - hdl/thumb_alu_expand.sv
      - hdl/thumb_ldst_expand.sv
      - hdl/decode_stage.sv
      - hdl/issue_queue.sv
      - hdl/thumb_expand_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_thumb_expand.sv
